// File: bench/reduceTreeTb.sv
`timescale 1ns/1ps
`default_nettype none

module reduceTreeTb;

	localparam logic [15:0] leafIdB = 16'd1;	// destId served by leaf B
	localparam int cycleLimit = 2000;	// Tests take about 400 cycles
	localparam int resultDelay = 3;	// Host release to result on hostOut
	localparam int waitLimit = 16;	// Give up on a result after this

	logic clock;
	logic reset;
	routeNetPkg::netBeat hostIn;
	routeNetPkg::netBeat hostOut;

	logic [31:0] lcgState;
	logic [31:0] beats[$];	// Data beats of the next session
	int cycleCount;
	int beatsToA;	// Beats with req seen on the leaf A path
	int beatsToB;

	reduceTree #(
		.leafIdB(leafIdB)
	) reduceTree_i (
		.clock(clock),
		.reset(reset),
		.hostIn(hostIn),
		.hostOut(hostOut)
	);

	//////////////////////////////////////////////////
	// Clock, run limit and branch monitor
	//////////////////////////////////////////////////

	initial begin
		clock = 1'b0;
		forever begin
			#2 clock = ~clock;
		end
	end

	always @(posedge clock) begin
		cycleCount = cycleCount + 1;
		if (cycleCount >= cycleLimit) begin
			$display("Run stopped after %0d cycles without finishing the tests", cycleCount);
			$display("Done: errors found");
			$fatal(1, "Cycle limit reached");
		end
	end

	// Counts what the router really steers to each leaf
	always @(posedge clock) begin
		if (reset) begin
			beatsToA <= 0;
			beatsToB <= 0;
		end else begin
			if (reduceTree_i.toLeafA.req) begin
				beatsToA <= beatsToA + 1;
			end
			if (reduceTree_i.toLeafB.req) begin
				beatsToB <= beatsToB + 1;
			end
		end
	end

	//////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////

	function automatic logic [31:0] nextRandom();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	// Expected reduction of the queued beats
	function automatic logic [31:0] refReduce(input reduceOpPkg::reduceOp op);
		logic [31:0] result;
		if (op == reduceOpPkg::opMin) begin
			result = reduceOpPkg::identityMin;
		end else begin
			result = 32'd0;
		end
		foreach (beats[i]) begin
			if (op == reduceOpPkg::opAdd) begin
				result = result + beats[i];	// Carry out is lost
			end else if (op == reduceOpPkg::opXor) begin
				result = result ^ beats[i];
			end else if (op == reduceOpPkg::opMax) begin
				if (beats[i] > result) begin
					result = beats[i];
				end
			end else if (beats[i] < result) begin
				result = beats[i];
			end
		end
		return result;
	endfunction

	task automatic checkEqual(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected) begin
			$display("** Error at %0t: %s, got %h, expected %h", $time, what, actual, expected);
			$display("Done: errors found");
			$fatal(1, "Check failed");
		end
	endtask

	task automatic setBeat(input logic req, input logic rls, input logic [31:0] data);
		hostIn.req = req;
		hostIn.rls = rls;
		hostIn.data = data;
	endtask

	task automatic driveBeat(input logic req, input logic rls, input logic [31:0] data);
		@(posedge clock);
		#1;
		setBeat(req, rls, data);
	endtask

	// Header, queued data beats, release, then the result and release come back
	task automatic runSession(input logic [15:0] destId, input reduceOpPkg::reduceOp op,
		input logic busyHeader);
		routeNetPkg::headerField hdr;
		routeNetPkg::headerField busyHdr;
		logic [31:0] expected;
		logic toB;
		logic gotBeat;
		int startA;
		int startB;
		int waited;

		expected = refReduce(op);
		toB = (destId == leafIdB);
		startA = beatsToA;
		startB = beatsToB;
		hdr.opcode = {14'd0, op};
		hdr.destId = destId;
		busyHdr.opcode = 16'd3;
		busyHdr.destId = toB ? 16'd0 : leafIdB;	// Aimed at the idle leaf

		driveBeat(1'b1, 1'b0, hdr);
		foreach (beats[i]) begin
			driveBeat(1'b1, 1'b0, beats[i]);
		end
		driveBeat(1'b0, 1'b1, 32'd0);

		waited = 0;
		gotBeat = 1'b0;
		while (!gotBeat && waited < waitLimit) begin
			@(posedge clock);
			#1;
			waited++;
			// Router is draining in the first cycle after the release
			if (busyHeader && waited == 1) begin
				setBeat(1'b1, 1'b0, busyHdr);
			end else begin
				setBeat(1'b0, 1'b0, 32'd0);
			end
			gotBeat = hostOut.req || hostOut.rls;
		end
		if (!gotBeat) begin
			$display("No result came back within %0d cycles of the host release", waited);
			$display("Done: errors found");
			$fatal(1, "Missing result");
		end

		checkEqual(32'(waited), 32'(resultDelay), "result latency after host release");
		checkEqual(32'(hostOut.req), 32'd1, "result beat req");
		checkEqual(32'(hostOut.rls), 32'd0, "result beat rls");
		checkEqual(hostOut.data, expected, "reduced value");

		@(posedge clock);
		#1;
		checkEqual(32'(hostOut.req), 32'd0, "release beat req");
		checkEqual(32'(hostOut.rls), 32'd1, "release beat rls");

		checkEqual(32'(beatsToA - startA), toB ? 32'd0 : 32'(beats.size() + 1),
			"beats steered to leaf A");
		checkEqual(32'(beatsToB - startB), toB ? 32'(beats.size() + 1) : 32'd0,
			"beats steered to leaf B");
	endtask

	//////////////////////////////////////////////////
	// Directed tests
	//////////////////////////////////////////////////

	task automatic checkResetQuiet();
		repeat (6) begin
			@(posedge clock);
			#1;
			checkEqual(32'(hostOut.req), 32'd0, "hostOut req after reset");
			checkEqual(32'(hostOut.rls), 32'd0, "hostOut rls after reset");
		end
	endtask

	task automatic sumFixedBeats();
		beats.delete();
		beats.push_back(32'hFFFF_FFF0);	// Forces a wrap
		beats.push_back(32'h0000_0025);
		beats.push_back(32'h1234_5678);
		beats.push_back(32'h8000_0000);
		beats.push_back(32'h7FFF_FFFF);
		runSession(16'd0, reduceOpPkg::opAdd, 1'b0);
	endtask

	task automatic selectBranchB();
		beats.delete();
		beats.push_back(32'hA5A5_0F0F);
		beats.push_back(32'h0000_FFFF);
		beats.push_back(32'h8000_0001);
		beats.push_back(32'h7FFF_FFFE);
		runSession(leafIdB, reduceOpPkg::opXor, 1'b0);
		runSession(leafIdB, reduceOpPkg::opMax, 1'b0);
	endtask

	task automatic returnIdentities();
		beats.delete();
		runSession(16'd0, reduceOpPkg::opAdd, 1'b0);
		runSession(leafIdB, reduceOpPkg::opMin, 1'b0);	// All ones back
	endtask

	task automatic runMixedStream();
		int count;
		logic [15:0] destId;
		reduceOpPkg::reduceOp op;
		for (int i = 0; i < 16; i++) begin
			beats.delete();
			count = nextRandom() >> 29;
			count = count + 1;	// 1 to 8 beats
			for (int j = 0; j < count; j++) begin
				beats.push_back(nextRandom());
			end
			if (i % 2 == 1) begin
				destId = leafIdB;
			end else if (i % 4 == 0) begin
				destId = 16'd0;
			end else begin
				destId = 16'h0A5C;	// Any other ID lands on A
			end
			op = reduceOpPkg::reduceOp'(2'((i / 2) % 4));
			runSession(destId, op, 1'b0);
		end
	endtask

	task automatic dropBusyHeader();
		beats.delete();
		beats.push_back(32'h0000_0011);
		beats.push_back(32'h0000_0022);
		beats.push_back(32'h0000_0044);
		runSession(16'd0, reduceOpPkg::opXor, 1'b1);
		runSession(leafIdB, reduceOpPkg::opAdd, 1'b1);
		repeat (4) begin
			@(posedge clock);
			#1;
			checkEqual(32'(hostOut.req), 32'd0, "hostOut req after stray header");
			checkEqual(32'(hostOut.rls), 32'd0, "hostOut rls after stray header");
		end
		runSession(leafIdB, reduceOpPkg::opMax, 1'b0);	// Leaf B must still be idle
	endtask

	//////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////

	initial begin
		reset = 1'b1;
		hostIn = '0;
		lcgState = 32'h8bd4_c365;
		cycleCount = 0;
		repeat (8) @(posedge clock);
		#1;
		reset = 1'b0;

		checkResetQuiet();
		sumFixedBeats();
		selectBranchB();
		returnIdentities();
		runMixedStream();
		dropBusyHeader();

		$display("Done: no errors");
		$finish;
	end

endmodule

`default_nettype wire

// File: design/reduceLeaf.sv
`timescale 1ns/1ps
`default_nettype none

module reduceLeaf (
	input logic clock,
	input logic reset,
	input routeNetPkg::netBeat fwdIn,	// Session beats from the router
	output routeNetPkg::netBeat backOut	// Result and release to the router
);

	typedef enum logic [1:0] {
		lfIdle,	// Waiting for a header
		lfAccum,	// Folding data beats
		lfRelease	// Result sent, release next
	} leafState;

	leafState state;
	routeNetPkg::headerField header;
	reduceOpPkg::reduceOp op;
	reduceOpPkg::reduceOp headerOp;
	logic [routeNetPkg::dataWidth-1:0] acc;
	logic [routeNetPkg::dataWidth-1:0] accNext;
	logic [routeNetPkg::dataWidth-1:0] startValue;

	//////////////////////////////////////////////////
	// Header decode and identity
	//////////////////////////////////////////////////

	assign header = routeNetPkg::headerField'(fwdIn.data);
	assign headerOp = reduceOpPkg::reduceOp'(header.opcode[1:0]);

	always_comb begin
		if (headerOp == reduceOpPkg::opMin) begin
			startValue = reduceOpPkg::identityMin;
		end else begin
			startValue = reduceOpPkg::identityZero;
		end
	end

	//////////////////////////////////////////////////
	// Reduction datapath
	//////////////////////////////////////////////////

	always_comb begin
		case (op)
			reduceOpPkg::opAdd: accNext = acc + fwdIn.data;	// Wraps at 2^32
			reduceOpPkg::opXor: accNext = acc ^ fwdIn.data;
			reduceOpPkg::opMax: accNext = (fwdIn.data > acc) ? fwdIn.data : acc;
			reduceOpPkg::opMin: accNext = (fwdIn.data < acc) ? fwdIn.data : acc;
			default: accNext = acc;
		endcase
	end

	always_ff @(posedge clock) begin
		if (state == lfIdle && fwdIn.req) begin
			op <= headerOp;
			acc <= startValue;
		end else if (state == lfAccum && fwdIn.req) begin
			acc <= accNext;
		end
	end

	//////////////////////////////////////////////////
	// Session control and return path
	//////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= lfIdle;
			backOut.req <= 1'b0;
			backOut.rls <= 1'b0;
		end else begin
			backOut.data <= acc;
			case (state)
				lfIdle: begin
					backOut.req <= 1'b0;
					backOut.rls <= 1'b0;
					if (fwdIn.req) begin
						state <= lfAccum;
					end
				end
				lfAccum: begin
					backOut.rls <= 1'b0;
					if (fwdIn.rls) begin
						backOut.req <= 1'b1;	// Result beat
						state <= lfRelease;
					end else begin
						backOut.req <= 1'b0;
					end
				end
				lfRelease: begin
					backOut.req <= 1'b0;
					backOut.rls <= 1'b1;	// Release right after result
					state <= lfIdle;
				end
				default: begin
					backOut.req <= 1'b0;
					backOut.rls <= 1'b0;
					state <= lfIdle;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: design/reduceOpPkg.sv
`default_nettype none

//////////////////////////////////////////////////
// Reduction operations
//////////////////////////////////////////////////

package reduceOpPkg;

	// Opcode carried in the low bits of the header
	typedef enum logic [1:0] {
		opAdd,	// Sum modulo 2^32
		opXor,	// Bitwise parity
		opMax,	// Unsigned maximum
		opMin	// Unsigned minimum
	} reduceOp;

	//////////////////////////////////////////////////
	// Start values of the accumulator
	//////////////////////////////////////////////////

	// Neutral for add, xor and unsigned max
	localparam logic [31:0] identityZero = 32'h0000_0000;

	// Neutral for unsigned min
	localparam logic [31:0] identityMin = 32'hFFFF_FFFF;

endpackage

`default_nettype wire

// File: design/reduceTree.sv
`timescale 1ns/1ps
`default_nettype none

module reduceTree #(
	parameter logic [15:0] leafIdB = 16'd1	// destId routed to leaf B
) (
	input logic clock,
	input logic reset,
	input routeNetPkg::netBeat hostIn,	// Sessions from host
	output routeNetPkg::netBeat hostOut	// Results to host
);

	routeNetPkg::netBeat toLeafA;
	routeNetPkg::netBeat toLeafB;
	routeNetPkg::netBeat fromLeafA;
	routeNetPkg::netBeat fromLeafB;

	//////////////////////////////////////////////////
	// Router and two leaves side by side
	//////////////////////////////////////////////////

	sessionRouter #(
		.branchBId(leafIdB)
	) router (
		.clock(clock),
		.reset(reset),
		.hostIn(hostIn),
		.branchOutA(toLeafA),
		.branchOutB(toLeafB),
		.branchInA(fromLeafA),
		.branchInB(fromLeafB),
		.hostOut(hostOut)
	);

	reduceLeaf leafA (
		.clock(clock),
		.reset(reset),
		.fwdIn(toLeafA),
		.backOut(fromLeafA)
	);

	reduceLeaf leafB (
		.clock(clock),
		.reset(reset),
		.fwdIn(toLeafB),
		.backOut(fromLeafB)
	);

endmodule

`default_nettype wire

// File: design/routeNetPkg.sv
`default_nettype none

//////////////////////////////////////////////////
// Network beat and header layout
//////////////////////////////////////////////////

package routeNetPkg;

	localparam int dataWidth = 32;	// One word per beat

	// One beat on a forward or backward path
	typedef struct packed {
		logic req;	// Beat is present
		logic rls;	// Release token
		logic [dataWidth-1:0] data;	// Payload word
	} netBeat;

	// Overlay of the header beat's data word
	typedef struct packed {
		logic [15:0] opcode;	// Only low 2 bits used
		logic [15:0] destId;	// Destination leaf
	} headerField;

	//////////////////////////////////////////////////
	// Router control
	//////////////////////////////////////////////////

	typedef enum logic [1:0] {
		stIdle,	// Waiting for a header
		stForward,	// Session open, beats pass through
		stDrain	// Host released, waiting for leaf release
	} routerState;

endpackage

`default_nettype wire

// File: design/sessionRouter.sv
`timescale 1ns/1ps
`default_nettype none

module sessionRouter #(
	parameter logic [15:0] branchBId = 16'd1	// Header destId that selects branch B
) (
	input logic clock,
	input logic reset,
	input routeNetPkg::netBeat hostIn,	// Forward path from host
	output routeNetPkg::netBeat branchOutA,	// Forward path to leaf A
	output routeNetPkg::netBeat branchOutB,	// Forward path to leaf B
	input routeNetPkg::netBeat branchInA,	// Backward path from leaf A
	input routeNetPkg::netBeat branchInB,	// Backward path from leaf B
	output routeNetPkg::netBeat hostOut	// Backward path to host
);

	routeNetPkg::routerState state;
	routeNetPkg::routerState nextState;
	routeNetPkg::headerField header;
	logic headerMatch;
	logic matched;	// Session belongs to branch B
	routeNetPkg::netBeat fwdA;
	routeNetPkg::netBeat fwdB;
	routeNetPkg::netBeat backSel;
	routeNetPkg::netBeat hostNext;

	//////////////////////////////////////////////////
	// Header decode
	//////////////////////////////////////////////////

	assign header = routeNetPkg::headerField'(hostIn.data);
	assign headerMatch = (header.destId == branchBId);

	//////////////////////////////////////////////////
	// Forward steering and FSM
	//////////////////////////////////////////////////

	always_comb begin
		nextState = state;
		fwdA = hostIn;
		fwdA.req = 1'b0;	// Unselected branch stays quiet
		fwdA.rls = 1'b0;
		fwdB = hostIn;
		fwdB.req = 1'b0;
		fwdB.rls = 1'b0;

		case (state)
			routeNetPkg::stIdle: begin
				// Only a header opens a session, stray releases are dropped
				if (hostIn.req) begin
					nextState = routeNetPkg::stForward;
					if (headerMatch) begin
						fwdB = hostIn;
					end else begin
						fwdA = hostIn;
					end
				end
			end
			routeNetPkg::stForward: begin
				if (matched) begin
					fwdB = hostIn;
				end else begin
					fwdA = hostIn;
				end
				if (hostIn.rls) begin
					nextState = routeNetPkg::stDrain;
				end
			end
			routeNetPkg::stDrain: begin
				// Host side is closed, nothing goes forward
				if (backSel.rls) begin
					nextState = routeNetPkg::stIdle;
				end
			end
			default: begin
				nextState = routeNetPkg::stIdle;
			end
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= routeNetPkg::stIdle;
		end else begin
			state <= nextState;
		end
	end

	// Latched once per session
	always_ff @(posedge clock) begin
		if (reset) begin
			matched <= 1'b0;
		end else if (state == routeNetPkg::stIdle && hostIn.req) begin
			matched <= headerMatch;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			branchOutA.req <= 1'b0;
			branchOutA.rls <= 1'b0;
			branchOutB.req <= 1'b0;
			branchOutB.rls <= 1'b0;
		end else begin
			branchOutA <= fwdA;	// One cycle forward latency
			branchOutB <= fwdB;
		end
	end

	//////////////////////////////////////////////////
	// Backward merge
	//////////////////////////////////////////////////

	assign backSel = matched ? branchInB : branchInA;

	always_comb begin
		hostNext = backSel;
		if (state == routeNetPkg::stIdle) begin
			hostNext.req = 1'b0;	// No session, no return traffic
			hostNext.rls = 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			hostOut.req <= 1'b0;
			hostOut.rls <= 1'b0;
		end else begin
			hostOut <= hostNext;	// One cycle backward latency
		end
	end

endmodule

`default_nettype wire

// File: runSim.sh
#!/bin/sh
# Build the reduction tree testbench with Verilator and run it

cd "$(dirname "$0")" &&
verilator --binary --timing -j 0 -f sources.f --top-module reduceTreeTb -Mdir obj_dir &&
./obj_dir/VreduceTreeTb ||
{ echo "Simulation failed"; exit 1; }

// File: sources.f
design/routeNetPkg.sv
design/reduceOpPkg.sv
design/sessionRouter.sv
design/reduceLeaf.sv
design/reduceTree.sv
bench/reduceTreeTb.sv
